//--- flist.f
+incdir+design
design/mbus_ice_pkg.sv
design/rx_framer.sv
design/tx_assembler.sv
design/host_stream_mux.sv
design/mbus_ice_bridge.sv
bench/tb_mbus_ice_bridge.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_mbus_ice_bridge
FLIST     ?= flist.f
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FLIST) --top-module $(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/tb_mbus_ice_bridge.sv
`timescale 1ns/1ps
`include "mbus_ice_settings.svh"

module tb_mbus_ice_bridge import mbus_ice_pkg::*; ();

    typedef enum int {CASE_RX, CASE_RX_FAIL, CASE_TX} case_kind_t;
    typedef struct {
        case_kind_t kind;
        int         words;
        bit         fail;
        bit         overlap;
    } case_row_t;

    localparam int NUM_ROWS = 7;

    logic clk = 1'b0;
    logic reset;
    logic [`MBUS_WORD_W-1:0] rx_addr, rx_data, tx_addr, tx_data;
    logic rx_req, rx_pend, rx_fail, rx_broadcast, rx_ack;
    logic [1:0] rx_control_bits;
    logic tx_req, tx_pend, tx_resp_ack, tx_ack, tx_succ, tx_fail;
    logic [`ICE_BYTE_W-1:0] host_char, out_data, global_counter;
    logic host_char_valid, host_char_last, host_char_ready;
    logic out_data_valid, out_frame_valid, global_counter_inc;

    case_row_t rows [NUM_ROWS];
    logic [31:0] lcg_state = 32'd61;
    int cycle_cnt = 0;
    int cycle_limit = 1000000;
    // expected host frames, split by source
    logic [`ICE_BYTE_W-1:0] rx_byte_q[$], ak_byte_q[$];
    int rx_len_q[$];
    acknak_t ak_kind_q[$];
    // expected transmit words
    logic [`MBUS_WORD_W-1:0] tx_data_q[$];
    bit tx_pend_q[$];
    logic [`MBUS_WORD_W-1:0] tx_addr_exp;
    bit tx_fail_exp;
    int tx_done_cnt = 0;
    // frame tracking in the monitor
    int cur_src = 0;
    int cur_left = 0;
    bit cur_first = 0;
    int rx_ack_seen = 0, rx_ack_exp = 0;
    int inc_seen = 0, inc_exp = 0;
    int resp_seen = 0, resp_exp = 0;

    mbus_ice_bridge i_dut (.*);

    always #2 clk = ~clk;

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic stop_with_error(string what);
        $display("error at %0t: %s", $time, what);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_byte(string name, logic [`ICE_BYTE_W-1:0] got,
                              logic [`ICE_BYTE_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_word(string name, logic [`MBUS_WORD_W-1:0] got,
                              logic [`MBUS_WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_kind(string name, acknak_t got, acknak_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s got %s expected %s", $time, name, got.name(), exp.name());
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    // behavioral mbus controller, transmit side
    always begin
        @(negedge clk);
        if (!reset && tx_req) begin
            check_word("tx_addr", tx_addr, tx_addr_exp);
            check_word("tx_data", tx_data, tx_data_q.pop_front());
            check_count("tx_pend", int'(tx_pend), int'(tx_pend_q.pop_front()));
            @(posedge clk);
            #1 tx_ack = 1'b1;
            do @(negedge clk); while (tx_req);
            @(posedge clk);
            #1 tx_ack = 1'b0;
            if (!tx_pend) begin
                // assembler needs a cycle to see ack fall
                @(posedge clk);
                #1;
                if (tx_fail_exp) tx_fail = 1'b1;
                else tx_succ = 1'b1;
                @(posedge clk);
                #1;
                tx_succ = 1'b0;
                tx_fail = 1'b0;
                @(negedge clk);
                check_count("tx_resp_ack", int'(tx_resp_ack), 1);
                tx_done_cnt++;
            end
        end
    end

    // host stream monitor
    always @(negedge clk) begin
        if (!reset) begin
            if (rx_ack) rx_ack_seen++;
            if (global_counter_inc) inc_seen++;
            if (tx_resp_ack) resp_seen++;
            if (out_data_valid) begin
                if (cur_src == 0) begin
                    // first byte tells which source owns the frame
                    if (out_data == `ICE_RX_EVENT_FLAG) begin
                        if (rx_len_q.size() == 0) stop_with_error("unexpected receive frame");
                        cur_src = 1;
                        cur_left = rx_len_q.pop_front();
                    end else begin
                        if (ak_kind_q.size() == 0) stop_with_error("unexpected ack/nak frame");
                        cur_src = 2;
                        cur_left = 3;
                        cur_first = 1'b1;
                    end
                end
                if (cur_left == 0) stop_with_error("host frame longer than expected");
                if (cur_src == 1) begin
                    check_byte("out_data", out_data, rx_byte_q.pop_front());
                end else begin
                    if (cur_first) check_kind("acknak code", acknak_t'(out_data[0]),
                                              ak_kind_q.pop_front());
                    cur_first = 1'b0;
                    check_byte("out_data", out_data, ak_byte_q.pop_front());
                end
                cur_left--;
            end
            if (!out_frame_valid && cur_src != 0) begin
                if (cur_left != 0) stop_with_error("host frame ended early");
                cur_src = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("the run timed out after %0d cycles", cycle_cnt);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    task automatic send_receive(int nwords);
        logic [31:0] tag, addr;
        logic [31:0] data [$];
        logic [2:0] flags [$];
        logic [3:0] status;
        logic [31:0] r;
        status = '0;
        tag = lcg_next();
        addr = lcg_next();
        for (int i = 0; i < nwords; i++) begin
            data.push_back(lcg_next());
            r = lcg_next();
            flags.push_back(r[2:0]);
            status |= {1'b0, r[2:0]};
        end
        // expected frame: flag, tag, address, data, status
        rx_byte_q.push_back(`ICE_RX_EVENT_FLAG);
        rx_byte_q.push_back(tag[7:0]);
        for (int b = 3; b >= 0; b--) rx_byte_q.push_back(addr[b*8 +: 8]);
        for (int i = 0; i < nwords; i++) begin
            for (int b = 3; b >= 0; b--) rx_byte_q.push_back(data[i][b*8 +: 8]);
        end
        rx_byte_q.push_back({4'b0, status});
        rx_len_q.push_back(7 + 4 * nwords);
        rx_ack_exp += nwords;
        inc_exp++;
        global_counter = tag[7:0];
        for (int i = 0; i < nwords; i++) begin
            rx_addr = addr;
            rx_data = data[i];
            rx_pend = (i != nwords - 1);
            rx_broadcast = flags[i][2];
            rx_control_bits = flags[i][1:0];
            rx_req = 1'b1;
            do @(negedge clk); while (!rx_ack);
            @(posedge clk);
            #1 rx_req = 1'b0;
        end
        rx_pend = 1'b0;
        while (rx_len_q.size() != 0 || cur_src == 1) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic send_failed_receive();
        rx_fail = 1'b1;
        rx_ack_exp++;
        do @(negedge clk); while (!rx_ack);
        @(posedge clk);
        #1 rx_fail = 1'b0;
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic send_transmit(int nwords, bit fail);
        logic [7:0] chars [$];
        logic [31:0] r, data;
        logic [7:0] eid;
        int start_done;
        r = lcg_next();
        eid = r[7:0];
        tx_addr_exp = lcg_next();
        tx_fail_exp = fail;
        chars.push_back(eid);
        for (int b = 3; b >= 0; b--) chars.push_back(tx_addr_exp[b*8 +: 8]);
        for (int i = 0; i < nwords; i++) begin
            data = lcg_next();
            tx_data_q.push_back(data);
            tx_pend_q.push_back(i != nwords - 1);
            for (int b = 3; b >= 0; b--) chars.push_back(data[b*8 +: 8]);
        end
        ak_kind_q.push_back(fail ? ACKNAK_NAK : ACKNAK_ACK);
        ak_byte_q.push_back(fail ? `ICE_NAK_CODE : `ICE_ACK_CODE);
        ak_byte_q.push_back(eid);
        ak_byte_q.push_back(`ICE_ACKNAK_LEN);
        resp_exp++;
        start_done = tx_done_cnt;
        for (int i = 0; i < chars.size(); i++) begin
            host_char = chars[i];
            host_char_valid = 1'b1;
            host_char_last = (i == chars.size() - 1);
            do @(negedge clk); while (!host_char_ready);
            @(posedge clk);
            #1;
        end
        host_char_valid = 1'b0;
        host_char_last = 1'b0;
        while (tx_done_cnt == start_done) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    initial begin
        int total_words;
        rows[0] = '{CASE_RX, 1, 1'b0, 1'b0};
        rows[1] = '{CASE_RX, 3, 1'b0, 1'b0};
        rows[2] = '{CASE_RX_FAIL, 1, 1'b0, 1'b0};
        rows[3] = '{CASE_TX, 1, 1'b0, 1'b0};
        rows[4] = '{CASE_TX, 3, 1'b0, 1'b0};
        rows[5] = '{CASE_TX, 2, 1'b1, 1'b0};
        rows[6] = '{CASE_TX, 2, 1'b0, 1'b1};
        total_words = 0;
        foreach (rows[i]) total_words += rows[i].words;
        cycle_limit = total_words * 40 + 200;
        reset = 1'b1;
        rx_addr = '0;
        rx_data = '0;
        rx_req = 1'b0;
        rx_pend = 1'b0;
        rx_fail = 1'b0;
        rx_broadcast = 1'b0;
        rx_control_bits = '0;
        tx_ack = 1'b0;
        tx_succ = 1'b0;
        tx_fail = 1'b0;
        host_char = '0;
        host_char_valid = 1'b0;
        host_char_last = 1'b0;
        global_counter = '0;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        check_count("host_char_ready", int'(host_char_ready), 1);
        check_count("out_frame_valid", int'(out_frame_valid), 0);
        check_count("out_data_valid", int'(out_data_valid), 0);
        check_count("rx_ack", int'(rx_ack), 0);
        check_count("tx_req", int'(tx_req), 0);
        check_count("tx_pend", int'(tx_pend), 0);
        check_count("tx_resp_ack", int'(tx_resp_ack), 0);
        check_count("global_counter_inc", int'(global_counter_inc), 0);
        @(posedge clk);
        #1;
        foreach (rows[i]) begin
            case (rows[i].kind)
                CASE_RX: send_receive(rows[i].words);
                CASE_RX_FAIL: send_failed_receive();
                default: begin
                    if (rows[i].overlap) begin
                        // receive competes with the pending ack
                        fork
                            send_transmit(rows[i].words, rows[i].fail);
                            begin
                                // receive frame opens while the last word is out
                                do @(negedge clk); while (!(tx_req && !tx_pend));
                                @(posedge clk);
                                #1;
                                send_receive(rows[i].words);
                            end
                        join
                    end else begin
                        send_transmit(rows[i].words, rows[i].fail);
                    end
                end
            endcase
        end
        while (rx_len_q.size() != 0 || ak_kind_q.size() != 0 || cur_src != 0)
            @(negedge clk);
        check_count("rx_ack pulses", rx_ack_seen, rx_ack_exp);
        check_count("global_counter_inc pulses", inc_seen, inc_exp);
        check_count("tx_resp_ack pulses", resp_seen, resp_exp);
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- design/mbus_ice_bridge.sv
`timescale 1ns/1ps
`include "mbus_ice_settings.svh"

module mbus_ice_bridge import mbus_ice_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    // mbus controller receive side
    input  logic [`MBUS_WORD_W-1:0] rx_addr,
    input  logic [`MBUS_WORD_W-1:0] rx_data,
    input  logic                    rx_req,
    input  logic                    rx_pend,
    input  logic                    rx_fail,
    input  logic                    rx_broadcast,
    input  logic [1:0]              rx_control_bits,
    output logic                    rx_ack,
    // mbus controller transmit side
    output logic [`MBUS_WORD_W-1:0] tx_addr,
    output logic [`MBUS_WORD_W-1:0] tx_data,
    output logic                    tx_req,
    output logic                    tx_pend,
    output logic                    tx_resp_ack,
    input  logic                    tx_ack,
    input  logic                    tx_succ,
    input  logic                    tx_fail,
    // host characters in
    input  logic [`ICE_BYTE_W-1:0]  host_char,
    input  logic                    host_char_valid,
    input  logic                    host_char_last,
    output logic                    host_char_ready,
    // host stream out
    output logic [`ICE_BYTE_W-1:0]  out_data,
    output logic                    out_data_valid,
    output logic                    out_frame_valid,
    // time tag source
    input  logic [`ICE_BYTE_W-1:0]  global_counter,
    output logic                    global_counter_inc
);

    // framer to merger
    logic [`ICE_BYTE_W-1:0] rx_byte;
    logic                   rx_byte_valid;
    logic                   rx_frame_active;
    logic                   rx_byte_ready;
    // assembler to merger
    logic                   acknak_valid;
    acknak_t                acknak_kind;
    logic [`ICE_BYTE_W-1:0] acknak_eid;

    rx_framer i_rx_framer (
        .clk               (clk),
        .reset             (reset),
        .rx_addr           (rx_addr),
        .rx_data           (rx_data),
        .rx_req            (rx_req),
        .rx_pend           (rx_pend),
        .rx_fail           (rx_fail),
        .rx_broadcast      (rx_broadcast),
        .rx_control_bits   (rx_control_bits),
        .rx_ack            (rx_ack),
        .global_counter    (global_counter),
        .global_counter_inc(global_counter_inc),
        .rx_byte           (rx_byte),
        .rx_byte_valid     (rx_byte_valid),
        .rx_frame_active   (rx_frame_active),
        .rx_byte_ready     (rx_byte_ready)
    );

    tx_assembler i_tx_assembler (
        .clk            (clk),
        .reset          (reset),
        .host_char      (host_char),
        .host_char_valid(host_char_valid),
        .host_char_last (host_char_last),
        .host_char_ready(host_char_ready),
        .tx_addr        (tx_addr),
        .tx_data        (tx_data),
        .tx_req         (tx_req),
        .tx_pend        (tx_pend),
        .tx_resp_ack    (tx_resp_ack),
        .tx_ack         (tx_ack),
        .tx_succ        (tx_succ),
        .tx_fail        (tx_fail),
        .acknak_valid   (acknak_valid),
        .acknak_kind    (acknak_kind),
        .acknak_eid     (acknak_eid)
    );

    host_stream_mux i_host_stream_mux (
        .clk            (clk),
        .reset          (reset),
        .rx_byte        (rx_byte),
        .rx_byte_valid  (rx_byte_valid),
        .rx_frame_active(rx_frame_active),
        .rx_byte_ready  (rx_byte_ready),
        .acknak_valid   (acknak_valid),
        .acknak_kind    (acknak_kind),
        .acknak_eid     (acknak_eid),
        .out_data       (out_data),
        .out_data_valid (out_data_valid),
        .out_frame_valid(out_frame_valid)
    );

endmodule

//--- design/host_stream_mux.sv
`timescale 1ns/1ps
`include "mbus_ice_settings.svh"

module host_stream_mux import mbus_ice_pkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    // receive frame bytes
    input  logic [`ICE_BYTE_W-1:0] rx_byte,
    input  logic                   rx_byte_valid,
    input  logic                   rx_frame_active,
    output logic                   rx_byte_ready,
    // transmit outcome
    input  logic                   acknak_valid,
    input  acknak_t                acknak_kind,
    input  logic [`ICE_BYTE_W-1:0] acknak_eid,
    // host output stream
    output logic [`ICE_BYTE_W-1:0] out_data,
    output logic                   out_data_valid,
    output logic                   out_frame_valid
);

    // code, event id, length, then one trailing cycle
    localparam logic [1:0] MSG_TAIL = 2'd3;

    mux_state_t             state;
    logic                   slot_full;
    acknak_t                slot_kind;
    logic [`ICE_BYTE_W-1:0] slot_eid;
    logic [1:0]             msg_idx;
    logic [`ICE_BYTE_W-1:0] msg_byte;
    logic                   start_msg;

    assign rx_byte_ready = (state == MUX_RX);
    assign out_frame_valid = (state != MUX_IDLE);
    // pending message wins only between frames
    assign start_msg = (state == MUX_IDLE) && slot_full;

    always_comb begin
        case (msg_idx)
            2'd0: msg_byte = (slot_kind == ACKNAK_NAK) ? `ICE_NAK_CODE : `ICE_ACK_CODE;
            2'd1: msg_byte = slot_eid;
            default: msg_byte = `ICE_ACKNAK_LEN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= MUX_IDLE;
            slot_full <= 1'b0;
            msg_idx <= '0;
            out_data_valid <= 1'b0;
        end else begin
            out_data_valid <= 1'b0;
            if (acknak_valid) begin
                slot_full <= 1'b1;
            end else if (start_msg) begin
                slot_full <= 1'b0;
            end
            case (state)
                MUX_IDLE: begin
                    msg_idx <= '0;
                    if (slot_full) begin
                        state <= MUX_ACK;
                    end else if (rx_frame_active) begin
                        state <= MUX_RX;
                    end
                end
                MUX_RX: begin
                    // ready is high here, so valid means accepted
                    out_data_valid <= rx_byte_valid;
                    if (!rx_frame_active) begin
                        state <= MUX_IDLE;
                    end
                end
                MUX_ACK: begin
                    msg_idx <= msg_idx + 2'd1;
                    out_data_valid <= (msg_idx != MSG_TAIL);
                    if (msg_idx == MSG_TAIL) begin
                        state <= MUX_IDLE;
                    end
                end
                default: begin
                    state <= MUX_IDLE;
                end
            endcase
        end
    end

    // output byte register and the one-entry slot
    always_ff @(posedge clk) begin
        if (state == MUX_ACK) begin
            out_data <= msg_byte;
        end else begin
            out_data <= rx_byte;
        end
        if (acknak_valid) begin
            slot_kind <= acknak_kind;
            slot_eid <= acknak_eid;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        out_data_valid |-> out_frame_valid);

endmodule

//--- design/tx_assembler.sv
`timescale 1ns/1ps
`include "mbus_ice_settings.svh"

module tx_assembler import mbus_ice_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    // host characters
    input  logic [`ICE_BYTE_W-1:0]  host_char,
    input  logic                    host_char_valid,
    input  logic                    host_char_last,
    output logic                    host_char_ready,
    // mbus transmit side
    output logic [`MBUS_WORD_W-1:0] tx_addr,
    output logic [`MBUS_WORD_W-1:0] tx_data,
    output logic                    tx_req,
    output logic                    tx_pend,
    output logic                    tx_resp_ack,
    input  logic                    tx_ack,
    input  logic                    tx_succ,
    input  logic                    tx_fail,
    // outcome toward the merger
    output logic                    acknak_valid,
    output acknak_t                 acknak_kind,
    output logic [`ICE_BYTE_W-1:0]  acknak_eid
);

    localparam int CNT_W = $clog2(`MBUS_BYTES_PER_WORD);
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(`MBUS_BYTES_PER_WORD - 1);

    tx_state_t        state;
    logic [CNT_W-1:0] byte_cnt;
    logic             char_xfer;
    logic             word_done;

    // characters only flow while collecting
    assign host_char_ready = (state == TX_IDLE) || (state == TX_ADDR) || (state == TX_DATA);
    assign char_xfer = host_char_valid && host_char_ready;
    assign word_done = char_xfer && (byte_cnt == LAST_BYTE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= TX_IDLE;
            byte_cnt <= '0;
            tx_req <= 1'b0;
            tx_pend <= 1'b0;
            tx_resp_ack <= 1'b0;
            acknak_valid <= 1'b0;
        end else begin
            tx_resp_ack <= 1'b0;
            acknak_valid <= 1'b0;
            case (state)
                TX_IDLE: begin
                    // event id char opens the frame
                    byte_cnt <= '0;
                    if (char_xfer) begin
                        state <= TX_ADDR;
                    end
                end
                TX_ADDR: begin
                    if (char_xfer) begin
                        byte_cnt <= byte_cnt + CNT_W'(1);
                    end
                    if (word_done) begin
                        state <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (char_xfer) begin
                        byte_cnt <= byte_cnt + CNT_W'(1);
                    end
                    if (word_done) begin
                        // more words follow unless this was the last char
                        tx_req <= 1'b1;
                        tx_pend <= !host_char_last;
                        state <= TX_REQUEST;
                    end
                end
                TX_REQUEST: begin
                    if (tx_ack) begin
                        tx_req <= 1'b0;
                        state <= TX_ACK_FALL;
                    end
                end
                TX_ACK_FALL: begin
                    // next request only after ack drops
                    if (!tx_ack) begin
                        state <= tx_pend ? TX_DATA : TX_WAIT_RESP;
                    end
                end
                TX_WAIT_RESP: begin
                    if (tx_succ || tx_fail) begin
                        tx_resp_ack <= 1'b1;
                        acknak_valid <= 1'b1;
                        state <= TX_IDLE;
                    end
                end
                default: begin
                    state <= TX_IDLE;
                end
            endcase
        end
    end

    // address, data and event id shift in msb first
    always_ff @(posedge clk) begin
        if (char_xfer) begin
            case (state)
                TX_IDLE: begin
                    acknak_eid <= host_char;
                end
                TX_ADDR: begin
                    tx_addr <= {tx_addr[`MBUS_WORD_W-`ICE_BYTE_W-1:0], host_char};
                end
                TX_DATA: begin
                    tx_data <= {tx_data[`MBUS_WORD_W-`ICE_BYTE_W-1:0], host_char};
                end
                default: begin
                end
            endcase
        end
        if (state == TX_WAIT_RESP && (tx_succ || tx_fail)) begin
            acknak_kind <= tx_fail ? ACKNAK_NAK : ACKNAK_ACK;
        end
    end

    // response handshake never overlaps a word request
    assert property (@(posedge clk) disable iff (reset)
        !(tx_req && tx_resp_ack));

endmodule

//--- design/rx_framer.sv
`timescale 1ns/1ps
`include "mbus_ice_settings.svh"

module rx_framer import mbus_ice_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    // word strobes from the mbus controller
    input  logic [`MBUS_WORD_W-1:0] rx_addr,
    input  logic [`MBUS_WORD_W-1:0] rx_data,
    input  logic                    rx_req,
    input  logic                    rx_pend,
    input  logic                    rx_fail,
    input  logic                    rx_broadcast,
    input  logic [1:0]              rx_control_bits,
    output logic                    rx_ack,
    // time tagging
    input  logic [`ICE_BYTE_W-1:0]  global_counter,
    output logic                    global_counter_inc,
    // byte stream toward the merger
    output logic [`ICE_BYTE_W-1:0]  rx_byte,
    output logic                    rx_byte_valid,
    output logic                    rx_frame_active,
    input  logic                    rx_byte_ready
);

    localparam int SR_W  = 2 * `MBUS_WORD_W;
    localparam int CNT_W = $clog2(2 * `MBUS_BYTES_PER_WORD);

    rx_state_t        state;
    logic [SR_W-1:0]  shift_reg;
    logic [CNT_W-1:0] byte_cnt;
    logic [3:0]       status;
    logic             first_word;
    logic             more_words;
    logic             byte_xfer;

    assign byte_xfer = rx_byte_valid && rx_byte_ready;
    assign rx_frame_active = (state != RX_IDLE);
    // counter advances as the tag leaves
    assign global_counter_inc = (state == RX_TIME) && rx_byte_ready;

    // byte select per state
    always_comb begin
        rx_byte = shift_reg[SR_W-1 -: `ICE_BYTE_W];
        rx_byte_valid = 1'b0;
        case (state)
            RX_FLAG: begin
                rx_byte = `ICE_RX_EVENT_FLAG;
                rx_byte_valid = 1'b1;
            end
            RX_TIME: begin
                rx_byte = global_counter;
                rx_byte_valid = 1'b1;
            end
            RX_EMIT: begin
                rx_byte_valid = 1'b1;
            end
            RX_STATUS: begin
                // status sits in the low nibble
                rx_byte = {{(`ICE_BYTE_W-4){1'b0}}, status};
                rx_byte_valid = 1'b1;
            end
            default: begin
                rx_byte_valid = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RX_IDLE;
            rx_ack <= 1'b0;
            status <= '0;
            first_word <= 1'b1;
            more_words <= 1'b0;
            byte_cnt <= '0;
        end else begin
            rx_ack <= 1'b0;
            case (state)
                RX_IDLE: begin
                    status <= '0;
                    first_word <= 1'b1;
                    if (rx_req) begin
                        state <= RX_CAPTURE;
                    end else if (rx_fail && !rx_ack) begin
                        // failed reception, single ack and no frame
                        rx_ack <= 1'b1;
                    end
                end
                RX_CAPTURE: begin
                    status <= status | {rx_fail, rx_broadcast, rx_control_bits};
                    more_words <= rx_pend;
                    first_word <= 1'b0;
                    // first word also carries the address
                    if (first_word) begin
                        byte_cnt <= CNT_W'(2 * `MBUS_BYTES_PER_WORD - 1);
                        state <= RX_FLAG;
                    end else begin
                        byte_cnt <= CNT_W'(`MBUS_BYTES_PER_WORD - 1);
                        state <= RX_EMIT;
                    end
                end
                RX_FLAG: begin
                    if (byte_xfer) begin
                        state <= RX_TIME;
                    end
                end
                RX_TIME: begin
                    if (byte_xfer) begin
                        state <= RX_EMIT;
                    end
                end
                RX_EMIT: begin
                    if (byte_xfer) begin
                        byte_cnt <= byte_cnt - CNT_W'(1);
                        if (byte_cnt == '0) begin
                            // word fully sent, release the controller
                            rx_ack <= 1'b1;
                            state <= more_words ? RX_WAIT_WORD : RX_STATUS;
                        end
                    end
                end
                RX_WAIT_WORD: begin
                    // old request still up during the ack pulse
                    if (rx_req && !rx_ack) begin
                        state <= RX_CAPTURE;
                    end
                end
                RX_STATUS: begin
                    if (byte_xfer) begin
                        state <= RX_IDLE;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // payload shifter, msb first
    always_ff @(posedge clk) begin
        if (state == RX_CAPTURE) begin
            if (first_word) begin
                shift_reg <= {rx_addr, rx_data};
            end else begin
                shift_reg <= {rx_data, {`MBUS_WORD_W{1'b0}}};
            end
        end else if (state == RX_EMIT && byte_xfer) begin
            shift_reg <= {shift_reg[SR_W-`ICE_BYTE_W-1:0], {`ICE_BYTE_W{1'b0}}};
        end
    end

    // merger relies on the frame window around every byte
    assert property (@(posedge clk) disable iff (reset)
        rx_byte_valid |-> rx_frame_active);

endmodule

//--- design/mbus_ice_pkg.sv
package mbus_ice_pkg;

    // receive framer sequence
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_CAPTURE,
        RX_FLAG,
        RX_TIME,
        RX_EMIT,
        RX_WAIT_WORD,
        RX_STATUS
    } rx_state_t;

    // transmit assembler sequence
    // event id is taken while idle
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_ADDR,
        TX_DATA,
        TX_REQUEST,
        TX_ACK_FALL,
        TX_WAIT_RESP
    } tx_state_t;

    // host output owner
    typedef enum logic [1:0] {
        MUX_IDLE,
        MUX_RX,
        MUX_ACK
    } mux_state_t;

    // transmit outcome reported to host
    typedef enum logic {
        ACKNAK_ACK,
        ACKNAK_NAK
    } acknak_t;

endpackage

//--- design/mbus_ice_settings.svh
`ifndef MBUS_ICE_SETTINGS_SVH
`define MBUS_ICE_SETTINGS_SVH

// mbus address and data word width
`define MBUS_WORD_W 32

// host side character width
`define ICE_BYTE_W 8

// bytes carried per mbus word
`define MBUS_BYTES_PER_WORD 4

// leading byte of every receive frame
`define ICE_RX_EVENT_FLAG 8'h62

// ack/nak message codes
`define ICE_ACK_CODE 8'h00
`define ICE_NAK_CODE 8'h01

// ack/nak frames carry no payload
`define ICE_ACKNAK_LEN 8'h00

`endif
